//--- hp_tx.f
logic/hp_pkg.sv
logic/tlp_wr_decoder.sv
logic/hp_reg_bank.sv
logic/qword_counter.sv
logic/page_drain_fsm.sv
logic/hp_tx_top.sv
testbench/hp_tx_tb.sv

//--- logic/hp_pkg.sv
package hp_pkg;

    //////////////////////////////////////////////////
    // tlp format/type codes (fmt[1:0], type[4:0])
    //////////////////////////////////////////////////
    localparam logic [6:0] MEM_WR32_FMT_TYPE = 7'b10_00000;   // 3dw header, with data
    localparam logic [6:0] MEM_WR64_FMT_TYPE = 7'b11_00000;   // 4dw header, with data

    // dword offsets inside bar 2
    localparam logic [5:0] REG_HP_ADDR_1   = 6'b100000;
    localparam logic [5:0] REG_HP_ADDR_2   = 6'b100010;
    localparam logic [5:0] REG_HP_UNLOCK_1 = 6'b101000;
    localparam logic [5:0] REG_HP_UNLOCK_2 = 6'b101001;
    localparam logic [5:0] REG_CPL_ADDR    = 6'b101100;

    localparam int         HP_BAR         = 2;
    localparam logic [4:0] MAX_REQ_QWORDS = 5'd16;            // largest read request
    localparam logic [63:0] QWORD_BYTES   = 64'd8;

    // decoder states, one-hot
    localparam logic [4:0] ST_IDLE = 5'b00001;
    localparam logic [4:0] ST_H3   = 5'b00010;                // 3dw, waiting on addr/data beat
    localparam logic [4:0] ST_D3   = 5'b00100;                // 3dw, second data dword
    localparam logic [4:0] ST_H4   = 5'b01000;                // 4dw, waiting on address beat
    localparam logic [4:0] ST_D4   = 5'b10000;                // 4dw, data beat

    // drain states
    localparam logic [1:0] DR_WAIT  = 2'd0;
    localparam logic [1:0] DR_CHECK = 2'd1;
    localparam logic [1:0] DR_REQ   = 2'd2;
    localparam logic [1:0] DR_CPL   = 2'd3;

    // second beat of a memory write, seen through either header format
    typedef union packed {
        struct packed {
            logic [31:0] addr_dw;
            logic [31:0] data_dw;
        } hdr3;
        struct packed {
            logic [31:0] addr_hi;
            logic [31:0] addr_lo;
        } hdr4;
    } tlp_beat_u;

    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_HP_ADDR_1,
        SEL_HP_ADDR_2,
        SEL_HP_UNLOCK_1,
        SEL_HP_UNLOCK_2,
        SEL_CPL_ADDR
    } reg_sel_e;

endpackage

//--- logic/hp_reg_bank.sv
`timescale 1ns/100ps

module hp_reg_bank
    import hp_pkg::*;
(
    input  logic        trn_clk,
    input  logic        reset,
    input  logic        wr_en_i,
    input  reg_sel_e    wr_sel_i,
    input  logic [63:0] wr_data_i,
    input  logic [1:0]  page_free_i,
    output logic [63:0] hp_addr_1_o,
    output logic [63:0] hp_addr_2_o,
    output logic [63:0] cpl_addr_o,
    output logic [31:0] hp_qwords_1_o,
    output logic [31:0] hp_qwords_2_o,
    output logic [1:0]  page_ready_o
);

    logic [63:0] swapped;
    logic [1:0]  unlock;

    // host data is little endian inside each dword
    function automatic logic [31:0] swap_dw(input logic [31:0] d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

    assign swapped = {swap_dw(wr_data_i[63:32]), swap_dw(wr_data_i[31:0])};

    assign unlock[0] = wr_en_i && (wr_sel_i == SEL_HP_UNLOCK_1);
    assign unlock[1] = wr_en_i && (wr_sel_i == SEL_HP_UNLOCK_2);

    //////////////////////////////////////////////////
    // page ready flags
    //////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            page_ready_o <= 2'b00;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (unlock[i]) begin
                    page_ready_o[i] <= 1'b1;     // unlock wins over free
                end else if (page_free_i[i]) begin
                    page_ready_o[i] <= 1'b0;
                end
            end
        end
    end

    // register values
    always_ff @(posedge trn_clk) begin
        if (wr_en_i) begin
            case (wr_sel_i)
                SEL_HP_ADDR_1:   hp_addr_1_o   <= swapped;
                SEL_HP_ADDR_2:   hp_addr_2_o   <= swapped;
                SEL_HP_UNLOCK_1: hp_qwords_1_o <= swapped[31:0];
                SEL_HP_UNLOCK_2: hp_qwords_2_o <= swapped[31:0];
                SEL_CPL_ADDR:    cpl_addr_o    <= swapped;
                default: begin
                end
            endcase
        end
    end

    // the drain side only frees a page it saw ready
    a_free_of_ready: assert property (@(posedge trn_clk) disable iff (reset)
        (page_free_i & ~page_ready_o) == 2'b00);

endmodule

//--- logic/hp_tx_top.sv
`timescale 1ns/100ps

module hp_tx_top
    import hp_pkg::*;
(
    input  logic        trn_clk,
    input  logic        reset,
    input  logic [63:0] trn_rd_i,
    input  logic        trn_rsof_n_i,
    input  logic        trn_reof_n_i,
    input  logic        trn_rsrc_rdy_n_i,
    input  logic        trn_rdst_rdy_n_i,
    input  logic [6:0]  trn_rbar_hit_n_i,
    input  logic        rd_req_ready_i,
    input  logic        cpl_ready_i,
    output logic        rd_req_valid_o,
    output logic [63:0] rd_req_addr_o,
    output logic [4:0]  rd_req_qwords_o,
    output logic        cpl_valid_o,
    output logic [63:0] cpl_addr_o,
    output logic        cpl_page_o
);

    logic        wr_en;
    reg_sel_e    wr_sel;
    logic [63:0] wr_data;
    logic [63:0] hp_addr_1;
    logic [63:0] hp_addr_2;
    logic [63:0] cpl_addr;
    logic [31:0] hp_qwords_1;
    logic [31:0] hp_qwords_2;
    logic [1:0]  page_ready;
    logic [1:0]  page_free;
    logic        load;
    logic [31:0] total;
    logic        step;
    logic [4:0]  chunk;
    logic        last;
    logic        empty;

    //////////////////////////////////////////////////
    // register path
    //////////////////////////////////////////////////
    tlp_wr_decoder tlp_wr_decoder_i (
        .trn_clk          (trn_clk),
        .reset            (reset),
        .trn_rd_i         (trn_rd_i),
        .trn_rsof_n_i     (trn_rsof_n_i),
        .trn_reof_n_i     (trn_reof_n_i),
        .trn_rsrc_rdy_n_i (trn_rsrc_rdy_n_i),
        .trn_rdst_rdy_n_i (trn_rdst_rdy_n_i),
        .trn_rbar_hit_n_i (trn_rbar_hit_n_i),
        .wr_en_o          (wr_en),
        .wr_sel_o         (wr_sel),
        .wr_data_o        (wr_data)
    );

    hp_reg_bank hp_reg_bank_i (
        .trn_clk       (trn_clk),
        .reset         (reset),
        .wr_en_i       (wr_en),
        .wr_sel_i      (wr_sel),
        .wr_data_i     (wr_data),
        .page_free_i   (page_free),
        .hp_addr_1_o   (hp_addr_1),
        .hp_addr_2_o   (hp_addr_2),
        .cpl_addr_o    (cpl_addr),
        .hp_qwords_1_o (hp_qwords_1),
        .hp_qwords_2_o (hp_qwords_2),
        .page_ready_o  (page_ready)
    );

    //////////////////////////////////////////////////
    // drain path
    //////////////////////////////////////////////////
    qword_counter qword_counter_i (
        .trn_clk (trn_clk),
        .reset   (reset),
        .load_i  (load),
        .total_i (total),
        .step_i  (step),
        .chunk_o (chunk),
        .last_o  (last),
        .empty_o (empty)
    );

    page_drain_fsm page_drain_fsm_i (
        .trn_clk         (trn_clk),
        .reset           (reset),
        .page_ready_i    (page_ready),
        .hp_addr_1_i     (hp_addr_1),
        .hp_addr_2_i     (hp_addr_2),
        .cpl_addr_i      (cpl_addr),
        .hp_qwords_1_i   (hp_qwords_1),
        .hp_qwords_2_i   (hp_qwords_2),
        .chunk_i         (chunk),
        .last_i          (last),
        .empty_i         (empty),
        .rd_req_ready_i  (rd_req_ready_i),
        .cpl_ready_i     (cpl_ready_i),
        .load_o          (load),
        .total_o         (total),
        .step_o          (step),
        .rd_req_valid_o  (rd_req_valid_o),
        .rd_req_addr_o   (rd_req_addr_o),
        .rd_req_qwords_o (rd_req_qwords_o),
        .page_free_o     (page_free),
        .cpl_valid_o     (cpl_valid_o),
        .cpl_addr_o      (cpl_addr_o),
        .cpl_page_o      (cpl_page_o)
    );

endmodule

//--- logic/page_drain_fsm.sv
`timescale 1ns/100ps

module page_drain_fsm
    import hp_pkg::*;
(
    input  logic        trn_clk,
    input  logic        reset,
    input  logic [1:0]  page_ready_i,
    input  logic [63:0] hp_addr_1_i,
    input  logic [63:0] hp_addr_2_i,
    input  logic [63:0] cpl_addr_i,
    input  logic [31:0] hp_qwords_1_i,
    input  logic [31:0] hp_qwords_2_i,
    input  logic [4:0]  chunk_i,
    input  logic        last_i,
    input  logic        empty_i,
    input  logic        rd_req_ready_i,
    input  logic        cpl_ready_i,
    output logic        load_o,
    output logic [31:0] total_o,
    output logic        step_o,
    output logic        rd_req_valid_o,
    output logic [63:0] rd_req_addr_o,
    output logic [4:0]  rd_req_qwords_o,
    output logic [1:0]  page_free_o,
    output logic        cpl_valid_o,
    output logic [63:0] cpl_addr_o,
    output logic        cpl_page_o
);

    logic [1:0] state;
    logic       cur;                    // 0 = page 1, 1 = page 2
    logic       cpl_done;
    logic       enter_cpl;

    assign load_o    = (state == DR_WAIT) && page_ready_i[cur];
    assign total_o   = cur ? hp_qwords_2_i : hp_qwords_1_i;
    assign step_o    = (state == DR_REQ) && rd_req_ready_i;     // request accepted
    assign cpl_done  = (state == DR_CPL) && cpl_ready_i;
    assign enter_cpl = ((state == DR_CHECK) && empty_i) || (step_o && last_i);

    assign page_free_o = {cpl_done && cur, cpl_done && !cur};
    assign cpl_page_o  = cur;

    //////////////////////////////////////////////////
    // drain control
    //////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state          <= DR_WAIT;
            cur            <= 1'b0;
            rd_req_valid_o <= 1'b0;
            cpl_valid_o    <= 1'b0;
        end else begin
            case (state)
                DR_WAIT: begin
                    if (load_o) begin
                        state <= DR_CHECK;       // counter settles first
                    end
                end
                DR_CHECK: begin
                    if (empty_i) begin
                        cpl_valid_o <= 1'b1;
                        state       <= DR_CPL;
                    end else begin
                        rd_req_valid_o <= 1'b1;
                        state          <= DR_REQ;
                    end
                end
                DR_REQ: begin
                    if (step_o) begin
                        rd_req_valid_o <= 1'b0;
                        if (last_i) begin
                            cpl_valid_o <= 1'b1;
                            state       <= DR_CPL;
                        end else begin
                            state <= DR_CHECK;
                        end
                    end
                end
                DR_CPL: begin
                    if (cpl_done) begin
                        cpl_valid_o <= 1'b0;
                        cur         <= !cur;     // strict alternation
                        state       <= DR_WAIT;
                    end
                end
                default: begin
                    state <= DR_WAIT;
                end
            endcase
        end
    end

    // request and notice payload
    always_ff @(posedge trn_clk) begin
        if (state == DR_WAIT) begin
            rd_req_addr_o <= cur ? hp_addr_2_i : hp_addr_1_i;
        end else if (step_o) begin
            rd_req_addr_o <= rd_req_addr_o + 64'(rd_req_qwords_o) * QWORD_BYTES;
        end
        if (state == DR_CHECK) begin
            rd_req_qwords_o <= chunk_i;
        end
        if (enter_cpl) begin
            cpl_addr_o <= cpl_addr_i;
        end
    end

    a_req_hold: assert property (@(posedge trn_clk) disable iff (reset)
        rd_req_valid_o && !rd_req_ready_i |=>
            rd_req_valid_o && $stable(rd_req_addr_o) && $stable(rd_req_qwords_o));

endmodule

//--- logic/qword_counter.sv
`timescale 1ns/100ps

module qword_counter
    import hp_pkg::*;
(
    input  logic        trn_clk,
    input  logic        reset,
    input  logic        load_i,
    input  logic [31:0] total_i,
    input  logic        step_i,
    output logic [4:0]  chunk_o,
    output logic        last_o,
    output logic        empty_o
);

    logic [31:0] remaining;             // qwords not yet requested

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            remaining <= '0;
        end else if (load_i) begin
            remaining <= total_i;
        end else if (step_i) begin
            remaining <= remaining - 32'(chunk_o);
        end
    end

    assign chunk_o = (remaining >= 32'(MAX_REQ_QWORDS)) ? MAX_REQ_QWORDS : remaining[4:0];
    assign empty_o = (remaining == '0);
    assign last_o  = !empty_o && (remaining <= 32'(MAX_REQ_QWORDS));

endmodule

//--- logic/tlp_wr_decoder.sv
`timescale 1ns/100ps

module tlp_wr_decoder
    import hp_pkg::*;
(
    input  logic        trn_clk,
    input  logic        reset,
    input  logic [63:0] trn_rd_i,
    input  logic        trn_rsof_n_i,
    input  logic        trn_reof_n_i,
    input  logic        trn_rsrc_rdy_n_i,
    input  logic        trn_rdst_rdy_n_i,
    input  logic [6:0]  trn_rbar_hit_n_i,
    output logic        wr_en_o,
    output reg_sel_e    wr_sel_o,
    output logic [63:0] wr_data_o
);

    logic [4:0]  state;
    logic        beat_ok;
    tlp_beat_u   beat;
    logic [5:0]  offset;
    reg_sel_e    beat_sel;
    reg_sel_e    sel_q;                     // register picked by the address beat
    logic [31:0] first_dw_q;                // 3dw path, first data dword
    logic        beat_unlock;
    logic        sel_q_unlock;

    assign beat_ok = !trn_rsrc_rdy_n_i && !trn_rdst_rdy_n_i;   // both sides ready
    assign beat    = trn_rd_i;

    // register offset sits in a different dword for each header format
    assign offset = (state == ST_H3) ? beat.hdr3.addr_dw[7:2] : beat.hdr4.addr_lo[7:2];

    always_comb begin
        case (offset)
            REG_HP_ADDR_1:   beat_sel = SEL_HP_ADDR_1;
            REG_HP_ADDR_2:   beat_sel = SEL_HP_ADDR_2;
            REG_HP_UNLOCK_1: beat_sel = SEL_HP_UNLOCK_1;
            REG_HP_UNLOCK_2: beat_sel = SEL_HP_UNLOCK_2;
            REG_CPL_ADDR:    beat_sel = SEL_CPL_ADDR;
            default:         beat_sel = SEL_NONE;
        endcase
    end

    assign beat_unlock  = (beat_sel == SEL_HP_UNLOCK_1) || (beat_sel == SEL_HP_UNLOCK_2);
    assign sel_q_unlock = (sel_q == SEL_HP_UNLOCK_1) || (sel_q == SEL_HP_UNLOCK_2);

    //////////////////////////////////////////////////
    // tlp parser
    //////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            wr_en_o <= 1'b0;
        end else begin
            wr_en_o <= 1'b0;                // single cycle strobe
            case (state)
                ST_IDLE: begin
                    if (beat_ok && !trn_rsof_n_i && trn_reof_n_i
                            && !trn_rbar_hit_n_i[HP_BAR]) begin
                        if (trn_rd_i[62:56] == MEM_WR32_FMT_TYPE) begin
                            state <= ST_H3;
                        end else if (trn_rd_i[62:56] == MEM_WR64_FMT_TYPE) begin
                            state <= ST_H4;
                        end
                    end
                end
                ST_H3: begin
                    if (beat_ok) begin
                        if (beat_sel == SEL_NONE) begin
                            state <= ST_IDLE;       // not one of ours
                        end else if (beat_unlock) begin
                            wr_en_o <= 1'b1;         // single dword, done here
                            state   <= ST_IDLE;
                        end else if (!trn_reof_n_i) begin
                            state <= ST_IDLE;       // 64-bit register, short write
                        end else begin
                            state <= ST_D3;
                        end
                    end
                end
                ST_D3: begin
                    if (beat_ok) begin
                        wr_en_o <= 1'b1;
                        state   <= ST_IDLE;
                    end
                end
                ST_H4: begin
                    if (beat_ok) begin
                        if (beat_sel == SEL_NONE || !trn_reof_n_i) begin
                            state <= ST_IDLE;
                        end else begin
                            state <= ST_D4;
                        end
                    end
                end
                ST_D4: begin
                    if (beat_ok) begin
                        wr_en_o <= 1'b1;
                        state   <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // strobe payload, valid only with wr_en_o
    always_ff @(posedge trn_clk) begin
        if (beat_ok) begin
            case (state)
                ST_H3: begin
                    sel_q      <= beat_sel;
                    first_dw_q <= beat.hdr3.data_dw;
                    wr_sel_o   <= beat_sel;
                    wr_data_o  <= {32'h0, beat.hdr3.data_dw};   // size for an unlock
                end
                ST_H4: begin
                    sel_q <= beat_sel;
                end
                ST_D3: begin
                    wr_sel_o  <= sel_q;
                    wr_data_o <= {trn_rd_i[63:32], first_dw_q};
                end
                ST_D4: begin
                    wr_sel_o <= sel_q;
                    if (sel_q_unlock) begin
                        wr_data_o <= {32'h0, trn_rd_i[63:32]};
                    end else begin
                        wr_data_o <= {trn_rd_i[31:0], trn_rd_i[63:32]};
                    end
                end
                default: begin
                end
            endcase
        end
    end

    a_state_onehot: assert property (@(posedge trn_clk) disable iff (reset)
        $onehot(state));

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the hp_tx testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f hp_tx.f --top-module hp_tx_tb \
    -Mdir obj_dir -o hp_tx_sim
./obj_dir/hp_tx_sim 2>&1 | tee sim.log

if grep -qx "Simulation completed successfully" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

//--- testbench/hp_tx_tb.sv
`timescale 1ns/100ps

module hp_tx_tb
    import hp_pkg::*;
();

    localparam logic [31:0] SEED        = 32'h283f_4ea6;
    localparam logic [6:0]  BAR_HIT     = 7'b111_1011;     // bar 2 only
    localparam logic [6:0]  BAR_MISS    = 7'b111_1110;     // bar 0 only
    localparam int          STALL_LIMIT = 1000;

    logic        trn_clk = 1'b0;
    logic        reset;
    logic [63:0] trn_rd;
    logic        trn_rsof_n;
    logic        trn_reof_n;
    logic        trn_rsrc_rdy_n;
    logic        trn_rdst_rdy_n = 1'b0;
    logic [6:0]  trn_rbar_hit_n;
    logic        rd_req_ready = 1'b0;
    logic        cpl_ready = 1'b0;
    logic        rd_req_valid;
    logic [63:0] rd_req_addr;
    logic [4:0]  rd_req_qwords;
    logic        cpl_valid;
    logic [63:0] cpl_addr;
    logic        cpl_page;

    logic [31:0] stim_state = SEED;
    logic [31:0] rdy_state = ~SEED;         // separate stream for the ready signals

    // reference model with page 1 at index 0
    logic [63:0] m_addr [2];
    logic [31:0] m_size [2];
    logic [63:0] m_cpl;
    logic        m_next;
    logic [63:0] exp_req_addr [$];
    logic [4:0]  exp_req_len [$];
    logic [63:0] exp_cpl_addr [$];
    logic        exp_cpl_page [$];
    string       test_name;

    always #2 trn_clk = !trn_clk;

    hp_tx_top hp_tx_top_i (
        .trn_clk          (trn_clk),
        .reset            (reset),
        .trn_rd_i         (trn_rd),
        .trn_rsof_n_i     (trn_rsof_n),
        .trn_reof_n_i     (trn_reof_n),
        .trn_rsrc_rdy_n_i (trn_rsrc_rdy_n),
        .trn_rdst_rdy_n_i (trn_rdst_rdy_n),
        .trn_rbar_hit_n_i (trn_rbar_hit_n),
        .rd_req_ready_i   (rd_req_ready),
        .cpl_ready_i      (cpl_ready),
        .rd_req_valid_o   (rd_req_valid),
        .rd_req_addr_o    (rd_req_addr),
        .rd_req_qwords_o  (rd_req_qwords),
        .cpl_valid_o      (cpl_valid),
        .cpl_addr_o       (cpl_addr),
        .cpl_page_o       (cpl_page)
    );

    //////////////////////////////////////////////////
    // random numbers and failure handling
    //////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] rand32();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("ERROR in %s: %s", test_name, what);
        abort_run();
    endtask

    task automatic check_req(input string name, input logic [63:0] exp_addr,
                             input logic [4:0] exp_len, input logic [63:0] act_addr,
                             input logic [4:0] act_len);
        if (act_addr !== exp_addr || act_len !== exp_len) begin
            $display("FAILED %s: request expected addr %h qwords %0d, actual addr %h qwords %0d",
                     name, exp_addr, exp_len, act_addr, act_len);
            abort_run();
        end
    endtask

    task automatic check_cpl(input string name, input logic [63:0] exp_addr,
                             input logic exp_page, input logic [63:0] act_addr,
                             input logic act_page);
        if (act_addr !== exp_addr || act_page !== exp_page) begin
            $display("FAILED %s: notice expected addr %h page %0d, actual addr %h page %0d",
                     name, exp_addr, exp_page, act_addr, act_page);
            abort_run();
        end
    endtask

    // output back-pressure plus the odd stall on the trn destination side
    always @(posedge trn_clk) begin
        rdy_state = xorshift32(rdy_state);
        rd_req_ready   <= rdy_state[1:0] != 2'b00;
        cpl_ready      <= rdy_state[3:2] != 2'b00;
        trn_rdst_rdy_n <= rdy_state[6:4] == 3'b000;
    end

    // handshakes sampled mid cycle complete on the next rising edge
    always @(negedge trn_clk) begin
        if (!reset && rd_req_valid && rd_req_ready) begin
            if (exp_req_addr.size() == 0) begin
                report_error("read request issued with none expected");
            end else begin
                check_req(test_name, exp_req_addr.pop_front(), exp_req_len.pop_front(),
                          rd_req_addr, rd_req_qwords);
            end
        end
        if (!reset && cpl_valid && cpl_ready) begin
            if (exp_cpl_addr.size() == 0) begin
                report_error("completion notice sent with none expected");
            end else begin
                check_cpl(test_name, exp_cpl_addr.pop_front(), exp_cpl_page.pop_front(),
                          cpl_addr, cpl_page);
            end
        end
    end

    //////////////////////////////////////////////////
    // trn stimulus
    //////////////////////////////////////////////////
    function automatic logic [31:0] host_dw(input logic [31:0] v);
        return {v[7:0], v[15:8], v[23:16], v[31:24]};  // little endian dword
    endfunction

    function automatic logic [5:0] reg_offset(input reg_sel_e sel);
        case (sel)
            SEL_HP_ADDR_1:   return REG_HP_ADDR_1;
            SEL_HP_ADDR_2:   return REG_HP_ADDR_2;
            SEL_HP_UNLOCK_1: return REG_HP_UNLOCK_1;
            SEL_HP_UNLOCK_2: return REG_HP_UNLOCK_2;
            default:         return REG_CPL_ADDR;
        endcase
    endfunction

    task automatic send_beat(input logic [63:0] data, input logic sof, input logic eof);
        int gaps;
        int waited;
        gaps   = rand32() % 3;
        waited = 0;
        for (int g = 0; g < gaps; g++) begin
            trn_rsrc_rdy_n <= 1'b1;             // source side gap
            @(posedge trn_clk);
        end
        trn_rd         <= data;
        trn_rsof_n     <= !sof;
        trn_reof_n     <= !eof;
        trn_rsrc_rdy_n <= 1'b0;
        @(posedge trn_clk);
        while (trn_rdst_rdy_n) begin
            waited++;
            if (waited > STALL_LIMIT) begin
                report_error("trn beat never accepted, destination ready stuck high");
            end
            @(posedge trn_clk);
        end
    endtask

    task automatic send_tlp(input logic [6:0] fmt_type, input logic [5:0] offset,
                            input logic [63:0] value, input logic [9:0] len,
                            input logic [6:0] bar_n);
        logic [31:0] d0;
        logic [31:0] d1;
        logic [31:0] addr_dw;
        logic [31:0] hdr0;
        d0            = host_dw(value[31:0]);
        d1            = host_dw(value[63:32]);
        addr_dw       = rand32();
        addr_dw[7:0]  = {offset, 2'b00};
        hdr0          = {1'b0, fmt_type, 14'h0, len};
        trn_rbar_hit_n <= bar_n;
        send_beat({hdr0, rand32()}, 1'b1, 1'b0);
        if (!fmt_type[6]) begin                 // no data means a read
            send_beat(fmt_type[5] ? {rand32(), addr_dw} : {addr_dw, rand32()}, 1'b0, 1'b1);
        end else if (fmt_type[5]) begin
            send_beat({rand32(), addr_dw}, 1'b0, 1'b0);
            send_beat(len == 10'd1 ? {d0, rand32()} : {d0, d1}, 1'b0, 1'b1);
        end else begin
            send_beat({addr_dw, d0}, 1'b0, len == 10'd1);
            if (len != 10'd1) begin
                send_beat({d1, rand32()}, 1'b0, 1'b1);
            end
        end
    endtask

    task automatic write_reg(input reg_sel_e sel, input logic [63:0] value, input logic use4);
        logic [9:0] len;
        len = (sel == SEL_HP_UNLOCK_1 || sel == SEL_HP_UNLOCK_2) ? 10'd1 : 10'd2;
        case (sel)
            SEL_HP_ADDR_1: m_addr[0] = value;
            SEL_HP_ADDR_2: m_addr[1] = value;
            SEL_CPL_ADDR:  m_cpl     = value;
            default: begin
            end
        endcase
        send_tlp(use4 ? MEM_WR64_FMT_TYPE : MEM_WR32_FMT_TYPE, reg_offset(sel), value, len,
                 BAR_HIT);
    endtask

    // tlps that must leave every register alone
    task automatic send_noise(input logic use4);
        logic [31:0] r;
        logic [5:0]  known;
        logic [6:0]  wr_type;
        r       = rand32();
        known   = reg_offset(r[3] ? (r[2] ? SEL_HP_ADDR_1 : SEL_HP_ADDR_2)
                                  : (r[2] ? SEL_CPL_ADDR : SEL_HP_UNLOCK_1));
        wr_type = use4 ? MEM_WR64_FMT_TYPE : MEM_WR32_FMT_TYPE;
        case (r[5:4])
            2'd0: send_tlp(wr_type, known, {rand32(), rand32()}, 10'd2, BAR_MISS);
            2'd1: send_tlp(wr_type, r[15] ? 6'h3f : {1'b0, r[12:8]}, {rand32(), rand32()},
                           10'd2, BAR_HIT);
            default: send_tlp(use4 ? 7'b01_00000 : 7'b00_00000, known, '0, 10'd2, BAR_HIT);
        endcase
    endtask

    //////////////////////////////////////////////////
    // model of the drain order
    //////////////////////////////////////////////////
    task automatic unlock_pages(input logic [1:0] pages, input logic [31:0] size_1,
                                input logic [31:0] size_2, input logic use4,
                                input logic reverse);
        logic [1:0]  left;
        logic [63:0] base;
        logic [31:0] full;
        logic [31:0] rest;
        logic        p;
        if (pages[0]) m_size[0] = size_1;
        if (pages[1]) m_size[1] = size_2;
        left = pages;
        while (left[m_next]) begin              // drained in turn whatever the unlock order
            base = m_addr[m_next];
            full = m_size[m_next] / 32'd16;
            rest = m_size[m_next] % 32'd16;
            for (int unsigned q = 0; q < full; q++) begin
                exp_req_addr.push_back(base + 64'(q) * 64'd128);   // 16 qwords of 8 bytes
                exp_req_len.push_back(5'd16);
            end
            if (rest != 32'd0) begin
                exp_req_addr.push_back(base + 64'(full) * 64'd128);
                exp_req_len.push_back(rest[4:0]);
            end
            exp_cpl_addr.push_back(m_cpl);
            exp_cpl_page.push_back(m_next);
            left[m_next] = 1'b0;
            m_next       = !m_next;
        end
        for (int k = 0; k < 2; k++) begin
            p = (k == 1) ^ reverse;
            if (pages[p]) begin
                write_reg(p ? SEL_HP_UNLOCK_2 : SEL_HP_UNLOCK_1,
                          {32'h0, p ? size_2 : size_1}, use4);
            end
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        trn_rsrc_rdy_n <= 1'b1;
        while (exp_req_addr.size() != 0 || exp_cpl_addr.size() != 0) begin
            @(posedge trn_clk);
            waited++;
            if (waited > STALL_LIMIT) begin
                report_error("drain stalled with requests or notices still outstanding");
            end
        end
    endtask

    task automatic random_phase();
        logic [31:0] r;
        logic [31:0] size_1;
        logic [31:0] size_2;
        int          writes;
        writes = rand32() % 6;
        for (int k = 0; k < writes; k++) begin
            r = rand32();
            if (r[0]) begin
                send_noise(r[1]);
            end else begin
                write_reg(r[3] ? (r[2] ? SEL_HP_ADDR_1 : SEL_HP_ADDR_2) : SEL_CPL_ADDR,
                          {rand32(), rand32()}, r[4]);
            end
        end
        r      = rand32();
        size_1 = rand32() % 70;
        size_2 = rand32() % 70;
        if (r[3:1] == 3'd0) size_1 = '0;
        if (r[6:4] == 3'd0) size_2 = '0;
        unlock_pages(r[0] ? 2'b11 : (m_next ? 2'b10 : 2'b01), size_1, size_2, r[7], r[8]);
        wait_drained();
    endtask

    initial begin
        reset          = 1'b1;
        trn_rd         = '0;
        trn_rsof_n     = 1'b1;
        trn_reof_n     = 1'b1;
        trn_rsrc_rdy_n = 1'b1;
        trn_rbar_hit_n = 7'h7f;
        m_next         = 1'b0;
        test_name      = "reset";
        repeat (3) @(posedge trn_clk);
        reset <= 1'b0;
        @(posedge trn_clk);

        // identical register values with 4dw then 3dw headers
        for (int f = 0; f < 2; f++) begin
            test_name = (f == 0) ? "4dw writes" : "3dw writes";
            write_reg(SEL_HP_ADDR_1, 64'h0000_0001_2345_6000, f == 0);
            write_reg(SEL_HP_ADDR_2, 64'h0000_0002_8000_1000, f == 0);
            write_reg(SEL_CPL_ADDR, 64'h0000_0003_0000_0040, f == 0);
            unlock_pages(2'b11, 32'd37, 32'd16, f == 0, 1'b0);
            wait_drained();
        end

        test_name = "zero size";
        unlock_pages(2'b01, 32'd0, 32'd0, 1'b1, 1'b0);
        wait_drained();

        test_name = "ignored tlps";
        for (int n = 0; n < 16; n++) begin
            send_noise(n[0]);
        end
        unlock_pages(2'b11, 32'd5, 32'd20, 1'b0, 1'b1);
        wait_drained();

        for (int n = 0; n < 40; n++) begin
            test_name = $sformatf("random phase %0d", n);
            random_phase();
        end

        test_name = "idle tail";
        repeat (50) @(posedge trn_clk);         // room for a late duplicate
        if (rd_req_valid !== 1'b0 || cpl_valid !== 1'b0) begin
            report_error("outputs still valid after the last page");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule
